// File: alu/z80_alu.sv
`timescale 1ns/1ps

// combinational 8-bit ALU
// A is the first operand and the data bus the second, flags that an
// operation does not define are passed through from flags_in
module z80_alu
  import z80_dp_pkg::*, z80_ctrl_pkg::*;
(
  input  byte_t   acc,
  input  byte_t   operand,
  input  alu_op_e op,
  input  flags_t  flags_in,
  output byte_t   result,
  output flags_t  flags_out
);

  // carry in for ADC, zero for a plain ADD
  logic       carry_in;

  // the add is split at the nibble so the half carry falls out directly
  logic [4:0] lo_sum;
  logic [4:0] hi_sum;
  byte_t      sum;

  // one extra bit catches the borrow out of bit 7
  logic [BYTE_W:0] diff;

  assign carry_in = (op == ALU_ADC) ? flags_in[FLAG_C] : 1'b0;
  assign lo_sum   = {1'b0, acc[3:0]} + {1'b0, operand[3:0]} + {4'b0, carry_in};
  assign hi_sum   = {1'b0, acc[7:4]} + {1'b0, operand[7:4]} + {4'b0, lo_sum[4]};
  assign sum      = {hi_sum[3:0], lo_sum[3:0]};
  assign diff     = {1'b0, acc} - {1'b0, operand};

  always_comb begin
    result    = acc;
    flags_out = flags_in;

    case (op)
      // increment touches no flag at all in this datapath
      ALU_INC: begin
        result = acc + 1'b1;
      end

      // PV reports a nonzero result, which the loop counters use
      ALU_DEC: begin
        result             = acc - 1'b1;
        flags_out[FLAG_PV] = (result != '0);
      end

      ALU_ADD, ALU_ADC: begin
        result             = sum;
        flags_out[FLAG_S]  = sum[BYTE_W-1];
        flags_out[FLAG_Z]  = (sum == '0);
        flags_out[FLAG_H]  = lo_sum[4];
        // overflow when both inputs share a sign that the result lost
        flags_out[FLAG_PV] = (acc[7] == operand[7]) && (sum[7] != acc[7]);
        flags_out[FLAG_N]  = 1'b0;
        flags_out[FLAG_C]  = hi_sum[4];
      end

      ALU_SUB: begin
        result             = diff[BYTE_W-1:0];
        flags_out[FLAG_S]  = diff[BYTE_W-1];
        flags_out[FLAG_Z]  = (diff[BYTE_W-1:0] == '0);
        // a borrow from bit 4 happens exactly when the low nibble of A is smaller
        flags_out[FLAG_H]  = (acc[3:0] < operand[3:0]);
        // overflow only when the signs differ and the result takes the operand's sign
        flags_out[FLAG_PV] = (acc[7] != operand[7]) && (diff[7] != acc[7]);
        flags_out[FLAG_N]  = 1'b1;
        flags_out[FLAG_C]  = diff[BYTE_W];
      end

      // moves a bus value through the ALU into A
      ALU_PASS: begin
        result = operand;
      end

      ALU_CCF: begin
        flags_out[FLAG_C] = ~flags_in[FLAG_C];
      end

      // loads F from the bus, used when F is popped from the stack
      ALU_LDF: begin
        flags_out = operand;
      end
    endcase
  end

endmodule

// File: common/z80_ctrl_pkg.sv
// encodings of the control fields that the control unit drives every cycle
package z80_ctrl_pkg;

  // operations of the 8-bit ALU
  typedef enum logic [2:0] {
    ALU_INC, ALU_DEC, ALU_ADD, ALU_ADC, ALU_SUB, ALU_PASS, ALU_CCF, ALU_LDF
  } alu_op_e;

  // byte registers of the register file
  // the high half of each pair sits right before its low half, the regfile
  // relies on that to find the low byte of a pair
  typedef enum logic [3:0] {
    REG_B, REG_C, REG_D, REG_E, REG_H, REG_L, REG_SPH, REG_SPL, REG_PCH, REG_PCL
  } reg_sel_e;

  // number of byte registers, and how many of them (B through L) have a shadow
  localparam int NUM_REGS   = 10;
  localparam int NUM_SHADOW = 6;

  // register pairs as seen from the address bus
  typedef enum logic [2:0] {
    PAIR_BC, PAIR_DE, PAIR_HL, PAIR_SP, PAIR_PC
  } pair_sel_e;

  // the single driver of the internal data bus, DSRC_EXT means data_in
  typedef enum logic [1:0] {
    DSRC_EXT, DSRC_REG, DSRC_A, DSRC_F
  } data_src_e;

  // the single driver of the internal address bus
  typedef enum logic [1:0] {
    ASRC_NONE, ASRC_MAR, ASRC_PAIR
  } addr_src_e;

  // MAR load modes, byte-wise from the data bus or whole from the address bus
  typedef enum logic [1:0] {
    MAR_HOLD, MAR_LO_DATA, MAR_HI_DATA, MAR_WORD
  } mar_ld_e;

  // per-flag override applied on top of the ALU flags
  typedef enum logic [1:0] {
    FLAG_KEEP, FLAG_SET, FLAG_CLR
  } flag_ctl_e;

endpackage

// File: common/z80_dp_pkg.sv
// widths and data types shared by every block of the 8-bit datapath
package z80_dp_pkg;

  // --------------------
  // bus widths
  // --------------------

  // the internal data bus and every byte register are this wide
  localparam int BYTE_W = 8;

  // the address bus, register pairs and the MAR are this wide
  localparam int WORD_W = 16;

  typedef logic [BYTE_W-1:0] byte_t;
  typedef logic [WORD_W-1:0] word_t;

  // F is kept as a plain byte so it can ride the data bus unchanged
  typedef logic [BYTE_W-1:0] flags_t;

  // --------------------
  // flag bit positions
  // --------------------

  // bits 5 and 3 are the undocumented copies and are never computed here
  localparam int FLAG_S  = 7;
  localparam int FLAG_Z  = 6;
  localparam int FLAG_H  = 4;
  localparam int FLAG_PV = 2;
  localparam int FLAG_N  = 1;
  localparam int FLAG_C  = 0;

endpackage

// File: regfile/z80_regfile.sv
`timescale 1ns/1ps

// main register file with its BC/DE/HL shadow bank
// bytes are written from the data bus and pairs from the address bus, and
// one read port of each width is always live for the bus arbiter
module z80_regfile
  import z80_dp_pkg::*, z80_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  byte_t     data_bus,
  input  word_t     addr_bus,
  input  logic      ld_reg_en,
  input  reg_sel_e  ld_reg_sel,
  input  logic      ld_pair_en,
  input  pair_sel_e ld_pair_sel,
  input  logic      exx,
  input  reg_sel_e  data_reg_sel,
  input  pair_sel_e addr_pair_sel,
  output byte_t     reg_byte,
  output word_t     reg_word
);

  // main bank is indexed directly by reg_sel_e
  byte_t main_q   [NUM_REGS];

  // shadow bank covers the first NUM_SHADOW entries only (B, C, D, E, H, L)
  // SP and PC are never exchanged
  byte_t shadow_q [NUM_SHADOW];

  // --------------------
  // pair decoding
  // --------------------

  // high byte of a pair
  function automatic reg_sel_e pair_hi(pair_sel_e p);
    case (p)
      PAIR_BC: return REG_B;
      PAIR_DE: return REG_D;
      PAIR_HL: return REG_H;
      PAIR_SP: return REG_SPH;
      default: return REG_PCH;
    endcase
  endfunction

  // the low byte always follows the high byte in the encoding
  function automatic reg_sel_e pair_lo(pair_sel_e p);
    return reg_sel_e'(pair_hi(p) + 1);
  endfunction

  // --------------------
  // read ports
  // --------------------

  assign reg_byte = main_q[data_reg_sel];
  assign reg_word = {main_q[pair_hi(addr_pair_sel)], main_q[pair_lo(addr_pair_sel)]};

  // --------------------
  // write port and exchange
  // --------------------

  // exx wins over any load, the assertions below keep the controls apart
  // anyway, so the order only matters for illegal control words
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        main_q[i] <= '0;
      end
      for (int i = 0; i < NUM_SHADOW; i++) begin
        shadow_q[i] <= '0;
      end
    end else if (exx) begin
      // whole bank swaps on one edge
      for (int i = 0; i < NUM_SHADOW; i++) begin
        main_q[i]   <= shadow_q[i];
        shadow_q[i] <= main_q[i];
      end
    end else if (ld_pair_en) begin
      main_q[pair_hi(ld_pair_sel)] <= addr_bus[WORD_W-1:BYTE_W];
      main_q[pair_lo(ld_pair_sel)] <= addr_bus[BYTE_W-1:0];
    end else if (ld_reg_en) begin
      main_q[ld_reg_sel] <= data_bus;
    end
  end

  // --------------------
  // control checks
  // --------------------

  // an exchange in the same cycle as a load would lose the loaded value
  assert property (@(posedge clk) disable iff (!rst_n)
    exx |-> !(ld_reg_en || ld_pair_en))
    else $error("regfile: exx issued together with a register load");

  // only one write port is used per cycle
  assert property (@(posedge clk) disable iff (!rst_n)
    !(ld_reg_en && ld_pair_en))
    else $error("regfile: byte and pair load in the same cycle");

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build the datapath testbench with Verilator and run it from the project root

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "cannot enter the project root"
  exit 1
fi

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_z80_datapath -f z80_datapath.f -o tb_z80_datapath
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/tb_z80_datapath 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "Result: PASSED"; then
  exit 0
fi
exit 1

// File: src/z80_acc_flags.sv
`timescale 1ns/1ps

// accumulator and flag register with their shadow copies
// F takes the ALU flags and then any per-bit overrides on the same edge
module z80_acc_flags
  import z80_dp_pkg::*, z80_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  byte_t     data_bus,
  input  byte_t     alu_result,
  input  flags_t    alu_flags,
  input  logic      ld_a,
  input  logic      a_from_alu,
  input  logic      ld_f,
  input  logic      ex_af,
  input  flag_ctl_e set_s,
  input  flag_ctl_e set_z,
  input  flag_ctl_e set_h,
  input  flag_ctl_e set_pv,
  input  flag_ctl_e set_n,
  input  flag_ctl_e set_c,
  output byte_t     acc,
  output flags_t    flags
);

  byte_t  a_q;
  byte_t  a_shadow_q;
  flags_t f_q;
  flags_t f_shadow_q;

  flags_t f_base;
  flags_t f_next;
  logic   f_we;

  // resolve one override against the bit it would otherwise take
  function automatic logic forced_bit(logic cur, flag_ctl_e ctl);
    case (ctl)
      FLAG_SET: return 1'b1;
      FLAG_CLR: return 1'b0;
      default:  return cur;
    endcase
  endfunction

  // --------------------
  // next F
  // --------------------

  // start from the ALU flags on a flag load, else from the current F
  always_comb begin
    f_base          = ld_f ? alu_flags : f_q;
    f_next          = f_base;
    f_next[FLAG_S]  = forced_bit(f_base[FLAG_S], set_s);
    f_next[FLAG_Z]  = forced_bit(f_base[FLAG_Z], set_z);
    f_next[FLAG_H]  = forced_bit(f_base[FLAG_H], set_h);
    f_next[FLAG_PV] = forced_bit(f_base[FLAG_PV], set_pv);
    f_next[FLAG_N]  = forced_bit(f_base[FLAG_N], set_n);
    f_next[FLAG_C]  = forced_bit(f_base[FLAG_C], set_c);
  end

  // any single override writes F even when ld_f is low
  assign f_we = ld_f || (set_s != FLAG_KEEP) || (set_z != FLAG_KEEP) ||
                (set_h != FLAG_KEEP) || (set_pv != FLAG_KEEP) ||
                (set_n != FLAG_KEEP) || (set_c != FLAG_KEEP);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      a_q        <= '0;
      a_shadow_q <= '0;
      f_q        <= '0;
      f_shadow_q <= '0;
    end else if (ex_af) begin
      // A and F always change bank together
      a_q        <= a_shadow_q;
      a_shadow_q <= a_q;
      f_q        <= f_shadow_q;
      f_shadow_q <= f_q;
    end else begin
      if (ld_a) begin
        a_q <= a_from_alu ? alu_result : data_bus;
      end
      if (f_we) begin
        f_q <= f_next;
      end
    end
  end

  assign acc   = a_q;
  assign flags = f_q;

  // a write to A or F in an exchange cycle would be dropped silently
  assert property (@(posedge clk) disable iff (!rst_n)
    ex_af |-> !(ld_a || f_we))
    else $error("acc_flags: ex_af issued together with an A or F write");

endmodule

// File: src/z80_bus_mar.sv
`timescale 1ns/1ps

// bus arbiter and memory address register
// exactly one source drives each internal bus, and the external outputs
// mirror those buses with an enable instead of a tristate
module z80_bus_mar
  import z80_dp_pkg::*, z80_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  byte_t     data_in,
  input  data_src_e data_src,
  input  addr_src_e addr_src,
  input  mar_ld_e   mar_ld,
  input  byte_t     reg_byte,
  input  word_t     reg_word,
  input  byte_t     acc,
  input  flags_t    flags,
  output byte_t     data_bus,
  output word_t     addr_bus,
  output byte_t     data_out,
  output logic      data_oe,
  output word_t     addr_out,
  output logic      addr_oe
);

  word_t mar_q;

  // --------------------
  // bus selection
  // --------------------

  // when nothing inside drives, the data bus listens to the outside
  always_comb begin
    case (data_src)
      DSRC_REG: data_bus = reg_byte;
      DSRC_A:   data_bus = acc;
      DSRC_F:   data_bus = flags;
      default:  data_bus = data_in;
    endcase
  end

  // an undriven address bus reads as zero
  always_comb begin
    case (addr_src)
      ASRC_MAR:  addr_bus = mar_q;
      ASRC_PAIR: addr_bus = reg_word;
      default:   addr_bus = '0;
    endcase
  end

  assign data_out = data_bus;
  assign data_oe  = (data_src != DSRC_EXT);
  assign addr_out = addr_bus;
  assign addr_oe  = (addr_src != ASRC_NONE);

  // byte loads let a 16-bit address be assembled from two memory reads
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mar_q <= '0;
    end else begin
      case (mar_ld)
        MAR_LO_DATA: mar_q[BYTE_W-1:0]      <= data_bus;
        MAR_HI_DATA: mar_q[WORD_W-1:BYTE_W] <= data_bus;
        MAR_WORD:    mar_q                  <= addr_bus;
        default:     mar_q                  <= mar_q;
      endcase
    end
  end

  // a word load has to come from a register pair, not from the MAR itself
  assert property (@(posedge clk) disable iff (!rst_n)
    (mar_ld == MAR_WORD) |-> (addr_src == ASRC_PAIR))
    else $error("bus_mar: MAR word load without a pair on the address bus");

endmodule

// File: src/z80_datapath.sv
`timescale 1ns/1ps

// top of the 8-bit datapath
// four peer blocks sit around one internal data bus and one internal
// address bus, and the control unit steers all of them cycle by cycle
module z80_datapath
  import z80_dp_pkg::*, z80_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  byte_t     data_in,
  input  data_src_e data_src,
  input  reg_sel_e  data_reg_sel,
  input  addr_src_e addr_src,
  input  pair_sel_e addr_pair_sel,
  input  logic      ld_reg_en,
  input  reg_sel_e  ld_reg_sel,
  input  logic      ld_pair_en,
  input  pair_sel_e ld_pair_sel,
  input  logic      exx,
  input  logic      ex_af,
  input  logic      ld_a,
  input  logic      a_from_alu,
  input  logic      ld_f,
  input  alu_op_e   alu_op,
  input  flag_ctl_e set_s,
  input  flag_ctl_e set_z,
  input  flag_ctl_e set_h,
  input  flag_ctl_e set_pv,
  input  flag_ctl_e set_n,
  input  flag_ctl_e set_c,
  input  mar_ld_e   mar_ld,
  output byte_t     data_out,
  output logic      data_oe,
  output word_t     addr_out,
  output logic      addr_oe,
  output flags_t    flags
);

  // --------------------
  // internal buses
  // --------------------

  byte_t  data_bus;
  word_t  addr_bus;

  // register file read ports feed the bus arbiter
  byte_t  reg_byte;
  word_t  reg_word;

  // A feeds both the ALU and the arbiter
  byte_t  acc;

  byte_t  alu_result;
  flags_t alu_flags;

  z80_regfile u_regfile (
    .clk           (clk),
    .rst_n         (rst_n),
    .data_bus      (data_bus),
    .addr_bus      (addr_bus),
    .ld_reg_en     (ld_reg_en),
    .ld_reg_sel    (ld_reg_sel),
    .ld_pair_en    (ld_pair_en),
    .ld_pair_sel   (ld_pair_sel),
    .exx           (exx),
    .data_reg_sel  (data_reg_sel),
    .addr_pair_sel (addr_pair_sel),
    .reg_byte      (reg_byte),
    .reg_word      (reg_word)
  );

  // the second ALU operand is always whatever sits on the data bus
  z80_alu u_alu (
    .acc       (acc),
    .operand   (data_bus),
    .op        (alu_op),
    .flags_in  (flags),
    .result    (alu_result),
    .flags_out (alu_flags)
  );

  z80_acc_flags u_acc_flags (
    .clk        (clk),
    .rst_n      (rst_n),
    .data_bus   (data_bus),
    .alu_result (alu_result),
    .alu_flags  (alu_flags),
    .ld_a       (ld_a),
    .a_from_alu (a_from_alu),
    .ld_f       (ld_f),
    .ex_af      (ex_af),
    .set_s      (set_s),
    .set_z      (set_z),
    .set_h      (set_h),
    .set_pv     (set_pv),
    .set_n      (set_n),
    .set_c      (set_c),
    .acc        (acc),
    .flags      (flags)
  );

  z80_bus_mar u_bus_mar (
    .clk       (clk),
    .rst_n     (rst_n),
    .data_in   (data_in),
    .data_src  (data_src),
    .addr_src  (addr_src),
    .mar_ld    (mar_ld),
    .reg_byte  (reg_byte),
    .reg_word  (reg_word),
    .acc       (acc),
    .flags     (flags),
    .data_bus  (data_bus),
    .addr_bus  (addr_bus),
    .data_out  (data_out),
    .data_oe   (data_oe),
    .addr_out  (addr_out),
    .addr_oe   (addr_oe)
  );

endmodule

// File: verification/tb_z80_datapath.sv
`timescale 1ns/1ps

// testbench for the 8-bit datapath
// a table of control words is applied one row per cycle, and every row carries
// the bus outputs and flags expected just before the next rising edge
module tb_z80_datapath
  import z80_dp_pkg::*, z80_ctrl_pkg::*;
();

  localparam int PERIOD       = 20;
  localparam int RESET_CYCLES = 4;
  // random rounds per ALU operation, each round takes four rows
  localparam int RAND_ITERS   = 8;

  // one action per row keeps the control words legal by construction
  typedef enum logic [3:0] {
    ACT_NONE, ACT_LD_REG, ACT_LD_PAIR, ACT_LD_A, ACT_LD_F, ACT_ALU,
    ACT_EXX, ACT_EX_AF, ACT_MAR_LO, ACT_MAR_HI, ACT_MAR_WORD
  } act_e;

  typedef struct packed {
    int        tid;
    data_src_e dsrc;
    reg_sel_e  rsel;
    addr_src_e asrc;
    pair_sel_e psel;
    act_e      act;
    alu_op_e   op;
    int        ovr_bit;
    flag_ctl_e ovr;
    byte_t     din;
    byte_t     exp_data;
    logic      exp_doe;
    word_t     exp_addr;
    logic      exp_aoe;
    flags_t    exp_flags;
  } row_t;

  logic      clk;
  logic      rst_n;
  byte_t     data_in;
  data_src_e data_src;
  reg_sel_e  data_reg_sel;
  addr_src_e addr_src;
  pair_sel_e addr_pair_sel;
  logic      ld_reg_en;
  reg_sel_e  ld_reg_sel;
  logic      ld_pair_en;
  pair_sel_e ld_pair_sel;
  logic      exx;
  logic      ex_af;
  logic      ld_a;
  logic      a_from_alu;
  logic      ld_f;
  alu_op_e   alu_op;
  flag_ctl_e set_s;
  flag_ctl_e set_z;
  flag_ctl_e set_h;
  flag_ctl_e set_pv;
  flag_ctl_e set_n;
  flag_ctl_e set_c;
  mar_ld_e   mar_ld;
  byte_t     data_out;
  logic      data_oe;
  word_t     addr_out;
  logic      addr_oe;
  flags_t    flags;

  row_t        rows[$];
  string       test_names[$];
  int          cur_test;
  logic        table_ready;
  logic [31:0] lcg_state;
  int          err_count;
  int          check_count;
  int          pass_tests;
  int          fail_tests;
  int          test_err_start;

  // values for B, C, D, E, H, L, SPH, SPL, PCH and PCL in that order
  byte_t reg_vals [NUM_REGS] = '{'h12, 'h34, 'h56, 'h78, 'h9a, 'hbc, 'hde, 'hf0, 'h13, 'h57};

  z80_datapath UUT (.*);

  always #(PERIOD/2) clk = ~clk;

  // --------------------
  // stimulus helpers
  // --------------------

  function automatic logic [31:0] lcg_next(logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // the upper byte of the LCG state has the longest period
  function byte_t rand_byte();
    lcg_state = lcg_next(lcg_state);
    return lcg_state[31:24];
  endfunction

  function automatic int signed_val(byte_t v);
    return v[7] ? int'(v) - 256 : int'(v);
  endfunction

  // reference ALU worked out in plain integers, returns {flags, result}
  function automatic logic [15:0] alu_model(alu_op_e op, byte_t a, byte_t b, flags_t f);
    byte_t  r;
    flags_t fo;
    int     cin;
    int     full;
    int     sres;
    r    = a;
    fo   = f;
    sres = 0;
    cin  = (op == ALU_ADC) ? int'(f[FLAG_C]) : 0;
    case (op)
      ALU_INC: r = a + 8'd1;
      ALU_DEC: begin
        r = a - 8'd1;
        fo[FLAG_PV] = (r != 8'h00);
      end
      ALU_ADD, ALU_ADC: begin
        full = int'(a) + int'(b) + cin;
        sres = signed_val(a) + signed_val(b) + cin;
        r = full[7:0];
        fo[FLAG_H] = (int'(a[3:0]) + int'(b[3:0]) + cin) > 15;
        fo[FLAG_C] = full > 255;
        fo[FLAG_N] = 1'b0;
      end
      ALU_SUB: begin
        full = int'(a) - int'(b);
        sres = signed_val(a) - signed_val(b);
        r = full[7:0];
        fo[FLAG_H] = int'(a[3:0]) < int'(b[3:0]);
        fo[FLAG_C] = full < 0;
        fo[FLAG_N] = 1'b1;
      end
      ALU_PASS: r = b;
      ALU_CCF:  fo[FLAG_C] = ~f[FLAG_C];
      ALU_LDF:  fo = b;
    endcase
    // sign, zero and overflow follow the same rule for add and subtract
    if (op inside {ALU_ADD, ALU_ADC, ALU_SUB}) begin
      fo[FLAG_S]  = r[7];
      fo[FLAG_Z]  = (r == 8'h00);
      fo[FLAG_PV] = (sres > 127) || (sres < -128);
    end
    return {fo, r};
  endfunction

  task automatic begin_test(string name);
    test_names.push_back(name);
    cur_test = test_names.size() - 1;
  endtask

  task automatic add_row(data_src_e ds, reg_sel_e rs, addr_src_e asrc, pair_sel_e ps,
                         act_e act, byte_t din, byte_t ed, logic edoe, word_t ea,
                         logic eaoe, flags_t ef);
    row_t r;
    r = '0;
    r.tid = cur_test;
    r.dsrc = ds;
    r.rsel = rs;
    r.asrc = asrc;
    r.psel = ps;
    r.act = act;
    r.din = din;
    r.exp_data = ed;
    r.exp_doe = edoe;
    r.exp_addr = ea;
    r.exp_aoe = eaoe;
    r.exp_flags = ef;
    rows.push_back(r);
  endtask

  // an override row leaves every bus idle, ef is F before the edge
  task automatic add_ovr(int bit_pos, flag_ctl_e ctl, flags_t ef);
    add_row(DSRC_EXT, REG_B, ASRC_NONE, PAIR_BC, ACT_NONE, 'h00, 'h00, 0, 'h0000, 0, ef);
    rows[rows.size()-1].ovr_bit = bit_pos;
    rows[rows.size()-1].ovr = ctl;
  endtask

  // F loaded from data_in through the ALU with one override on the same edge
  // ef is F before the edge
  task automatic add_flag_load(byte_t din, int bit_pos, flag_ctl_e ctl, flags_t ef);
    add_row(DSRC_EXT, REG_B, ASRC_NONE, PAIR_BC, ACT_LD_F, din, din, 0, 'h0000, 0, ef);
    rows[rows.size()-1].op = ALU_LDF;
    rows[rows.size()-1].ovr_bit = bit_pos;
    rows[rows.size()-1].ovr = ctl;
  endtask

  task automatic apply_row(row_t r);
    data_in       = r.din;
    data_src      = r.dsrc;
    data_reg_sel  = r.rsel;
    ld_reg_sel    = r.rsel;
    addr_src      = r.asrc;
    addr_pair_sel = r.psel;
    ld_pair_sel   = r.psel;
    alu_op        = r.op;
    ld_reg_en     = (r.act == ACT_LD_REG);
    ld_pair_en    = (r.act == ACT_LD_PAIR);
    exx           = (r.act == ACT_EXX);
    ex_af         = (r.act == ACT_EX_AF);
    ld_a          = (r.act == ACT_LD_A) || (r.act == ACT_ALU);
    a_from_alu    = (r.act == ACT_ALU);
    ld_f          = (r.act == ACT_LD_F) || (r.act == ACT_ALU);
    case (r.act)
      ACT_MAR_LO:   mar_ld = MAR_LO_DATA;
      ACT_MAR_HI:   mar_ld = MAR_HI_DATA;
      ACT_MAR_WORD: mar_ld = MAR_WORD;
      default:      mar_ld = MAR_HOLD;
    endcase
    set_s  = (r.ovr_bit == FLAG_S) ? r.ovr : FLAG_KEEP;
    set_z  = (r.ovr_bit == FLAG_Z) ? r.ovr : FLAG_KEEP;
    set_h  = (r.ovr_bit == FLAG_H) ? r.ovr : FLAG_KEEP;
    set_pv = (r.ovr_bit == FLAG_PV) ? r.ovr : FLAG_KEEP;
    set_n  = (r.ovr_bit == FLAG_N) ? r.ovr : FLAG_KEEP;
    set_c  = (r.ovr_bit == FLAG_C) ? r.ovr : FLAG_KEEP;
  endtask

  // --------------------
  // compare tasks
  // --------------------

  task automatic check_byte(string name, byte_t got, byte_t exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_word(string name, word_t got, word_t exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_flags(string name, flags_t got, flags_t exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_row(int i, row_t r);
    check_byte($sformatf("row %0d data_out", i), data_out, r.exp_data);
    check_bit($sformatf("row %0d data_oe", i), data_oe, r.exp_doe);
    check_word($sformatf("row %0d addr_out", i), addr_out, r.exp_addr);
    check_bit($sformatf("row %0d addr_oe", i), addr_oe, r.exp_aoe);
    check_flags($sformatf("row %0d flags", i), flags, r.exp_flags);
  endtask

  // --------------------
  // table
  // --------------------

  task automatic build_table();
    alu_op_e     op;
    byte_t       rf;
    byte_t       ra;
    byte_t       rb;
    flags_t      prev_f;
    logic [15:0] model;
    begin_test("reset and idle buses");
    add_row(DSRC_EXT, REG_B, ASRC_NONE, PAIR_BC, ACT_NONE, 'h5a, 'h5a, 0, 'h0000, 0, 'h00);
    add_row(DSRC_A, REG_B, ASRC_NONE, PAIR_BC, ACT_NONE, 'h5a, 'h00, 1, 'h0000, 0, 'h00);

    begin_test("byte register loads");
    for (int i = 0; i < NUM_REGS; i++) begin
      add_row(DSRC_EXT, reg_sel_e'(i), ASRC_NONE, PAIR_BC, ACT_LD_REG, reg_vals[i],
              reg_vals[i], 0, 'h0000, 0, 'h00);
    end
    for (int i = 0; i < NUM_REGS; i++) begin
      add_row(DSRC_REG, reg_sel_e'(i), ASRC_NONE, PAIR_BC, ACT_NONE, 'h00,
              reg_vals[i], 1, 'h0000, 0, 'h00);
    end
    // PCH above PCL on the address bus
    add_row(DSRC_EXT, REG_B, ASRC_PAIR, PAIR_PC, ACT_NONE, 'h00, 'h00, 0, 'h1357, 1, 'h00);

    begin_test("MAR byte build and word copies");
    add_row(DSRC_EXT, REG_B, ASRC_NONE, PAIR_BC, ACT_MAR_LO, 'hcd, 'hcd, 0, 'h0000, 0, 'h00);
    add_row(DSRC_EXT, REG_B, ASRC_NONE, PAIR_BC, ACT_MAR_HI, 'hab, 'hab, 0, 'h0000, 0, 'h00);
    add_row(DSRC_EXT, REG_B, ASRC_MAR, PAIR_BC, ACT_NONE, 'h00, 'h00, 0, 'habcd, 1, 'h00);
    add_row(DSRC_EXT, REG_B, ASRC_MAR, PAIR_DE, ACT_LD_PAIR, 'h00, 'h00, 0, 'habcd, 1, 'h00);
    add_row(DSRC_REG, REG_D, ASRC_PAIR, PAIR_DE, ACT_NONE, 'h00, 'hab, 1, 'habcd, 1, 'h00);
    add_row(DSRC_REG, REG_E, ASRC_NONE, PAIR_DE, ACT_NONE, 'h00, 'hcd, 1, 'h0000, 0, 'h00);
    add_row(DSRC_EXT, REG_B, ASRC_PAIR, PAIR_SP, ACT_MAR_WORD, 'h00, 'h00, 0, 'hdef0, 1, 'h00);
    add_row(DSRC_EXT, REG_B, ASRC_MAR, PAIR_BC, ACT_NONE, 'h00, 'h00, 0, 'hdef0, 1, 'h00);

    // each override is issued with ld_f low and must move only its own bit
    begin_test("flag overrides");
    add_ovr(FLAG_S, FLAG_SET, 'h00);
    add_ovr(FLAG_Z, FLAG_SET, 'h80);
    add_ovr(FLAG_H, FLAG_SET, 'hc0);
    add_ovr(FLAG_PV, FLAG_SET, 'hd0);
    add_ovr(FLAG_N, FLAG_SET, 'hd4);
    add_ovr(FLAG_C, FLAG_SET, 'hd6);
    add_ovr(FLAG_S, FLAG_CLR, 'hd7);
    add_ovr(FLAG_C, FLAG_CLR, 'h57);
    // with ld_f high the override lands on top of the freshly loaded flags
    add_flag_load('h0f, FLAG_S, FLAG_SET, 'h56);
    add_flag_load('hf1, FLAG_C, FLAG_CLR, 'h8f);
    add_flag_load('h56, FLAG_C, FLAG_KEEP, 'hf0);
    add_row(DSRC_F, REG_B, ASRC_NONE, PAIR_BC, ACT_NONE, 'h00, 'h56, 1, 'h0000, 0, 'h56);

    // BC, DE and HL hold 1234, abcd and 9abc here, the shadows are still zero
    begin_test("exx bank swap");
    add_row(DSRC_EXT, REG_B, ASRC_NONE, PAIR_BC, ACT_EXX, 'h00, 'h00, 0, 'h0000, 0, 'h56);
    add_row(DSRC_REG, REG_B, ASRC_PAIR, PAIR_HL, ACT_NONE, 'h00, 'h00, 1, 'h0000, 1, 'h56);
    add_row(DSRC_REG, REG_L, ASRC_PAIR, PAIR_SP, ACT_NONE, 'h00, 'h00, 1, 'hdef0, 1, 'h56);
    add_row(DSRC_EXT, REG_B, ASRC_NONE, PAIR_BC, ACT_EXX, 'h00, 'h00, 0, 'h0000, 0, 'h56);
    add_row(DSRC_REG, REG_C, ASRC_PAIR, PAIR_DE, ACT_NONE, 'h00, 'h34, 1, 'habcd, 1, 'h56);
    add_row(DSRC_REG, REG_H, ASRC_PAIR, PAIR_HL, ACT_NONE, 'h00, 'h9a, 1, 'h9abc, 1, 'h56);

    begin_test("ex_af swap");
    add_row(DSRC_EXT, REG_B, ASRC_NONE, PAIR_BC, ACT_LD_A, 'ha5, 'ha5, 0, 'h0000, 0, 'h56);
    add_row(DSRC_A, REG_B, ASRC_NONE, PAIR_BC, ACT_EX_AF, 'h00, 'ha5, 1, 'h0000, 0, 'h56);
    add_row(DSRC_A, REG_B, ASRC_NONE, PAIR_BC, ACT_NONE, 'h00, 'h00, 1, 'h0000, 0, 'h00);
    add_row(DSRC_F, REG_B, ASRC_NONE, PAIR_BC, ACT_EX_AF, 'h00, 'h00, 1, 'h0000, 0, 'h00);
    add_row(DSRC_A, REG_B, ASRC_NONE, PAIR_BC, ACT_NONE, 'h00, 'ha5, 1, 'h0000, 0, 'h56);
    add_row(DSRC_F, REG_B, ASRC_NONE, PAIR_BC, ACT_NONE, 'h00, 'h56, 1, 'h0000, 0, 'h56);

    // a round loads F, then A, runs the operation and reads the result back
    prev_f = 'h56;
    for (int k = 0; k < 8; k++) begin
      op = alu_op_e'(k);
      begin_test($sformatf("random %s", op.name()));
      for (int n = 0; n < RAND_ITERS; n++) begin
        rf = rand_byte();
        ra = rand_byte();
        rb = rand_byte();
        model = alu_model(op, ra, rb, rf);
        add_row(DSRC_EXT, REG_B, ASRC_NONE, PAIR_BC, ACT_LD_F, rf, rf, 0, 'h0000, 0, prev_f);
        rows[rows.size()-1].op = ALU_LDF;
        add_row(DSRC_EXT, REG_B, ASRC_NONE, PAIR_BC, ACT_LD_A, ra, ra, 0, 'h0000, 0, rf);
        add_row(DSRC_EXT, REG_B, ASRC_NONE, PAIR_BC, ACT_ALU, rb, rb, 0, 'h0000, 0, rf);
        rows[rows.size()-1].op = op;
        add_row(DSRC_A, REG_B, ASRC_NONE, PAIR_BC, ACT_NONE, 'h00, model[7:0], 1, 'h0000, 0,
                model[15:8]);
        prev_f = model[15:8];
      end
    end
  endtask

  // --------------------
  // run
  // --------------------

  // the deadline follows the table length plus reset and some margin
  initial begin
    wait (table_ready === 1'b1);
    #((rows.size() + RESET_CYCLES + 20) * PERIOD);
    $display("timeout: the table did not finish within the expected number of cycles");
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    row_t idle;
    int   errs;
    clk = 1'b0;
    rst_n = 1'b0;
    idle = '0;
    apply_row(idle);
    err_count = 0;
    check_count = 0;
    pass_tests = 0;
    fail_tests = 0;
    test_err_start = 0;
    lcg_state = 32'haeda7c75;
    table_ready = 1'b0;
    build_table();
    table_ready = 1'b1;

    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    for (int i = 0; i < rows.size(); i++) begin
      @(negedge clk);
      apply_row(rows[i]);
      // sample shortly before the rising edge that commits the row
      #(PERIOD/2 - 2);
      check_row(i, rows[i]);
      if (i == rows.size() - 1 || rows[i+1].tid != rows[i].tid) begin
        errs = err_count - test_err_start;
        test_err_start = err_count;
        if (errs == 0) begin
          pass_tests++;
        end else begin
          fail_tests++;
        end
        $display("test %0d %s: %s (%0d errors)", rows[i].tid, test_names[rows[i].tid],
                 (errs == 0) ? "ok" : "fail", errs);
      end
    end

    $display("summary: %0d tests passed, %0d failed, %0d checks, %0d errors",
             pass_tests, fail_tests, check_count, err_count);
    if (err_count == 0 && fail_tests == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: z80_datapath.f
common/z80_dp_pkg.sv
common/z80_ctrl_pkg.sv
regfile/z80_regfile.sv
alu/z80_alu.sv
src/z80_acc_flags.sv
src/z80_bus_mar.sv
src/z80_datapath.sv
verification/tb_z80_datapath.sv
